/* files.f */
rv_pkg.sv
rv_regfile.sv
rv_decode.sv
rv_uop_fifo.sv
rv_execute.sv
rv_core.sv
rv_core_chk.sv
rv_core_tb.sv

/* rv_core.sv */
module rv_core import rv_pkg::*; (
	input	logic				clock_i,
	input	logic				arst_n_i,

	// instruction stream in
	input	logic				inst_valid_i,
	input	logic	[XLEN-1:0]	inst_data_i,
	output	logic				inst_ready_o,

	// retire stream out
	output	logic				wb_valid_o,
	output	logic	[REG_AW-1:0]	wb_rd_o,
	output	logic	[XLEN-1:0]	wb_data_o,
	output	logic	[XLEN-1:0]	wb_pc_o,
	input	logic				wb_ready_i
);

	// decode to FIFO
	logic				dec_valid;
	logic	[UOP_W-1:0]	dec_uop;
	logic				dec_ready;

	// FIFO to execute
	logic				uop_valid;
	logic	[UOP_W-1:0]	uop_data;
	logic				uop_ready;

	rv_decode u_decode (
		.clock_i		(clock_i),
		.arst_n_i		(arst_n_i),
		.inst_valid_i	(inst_valid_i),
		.inst_data_i	(inst_data_i),
		.inst_ready_o	(inst_ready_o),
		.dec_valid_o	(dec_valid),
		.dec_uop_o		(dec_uop),
		.dec_ready_i	(dec_ready)
	);

	rv_uop_fifo #(
		.DEPTH	(UOP_FIFO_DEPTH)
	) u_uop_fifo (
		.clock_i	(clock_i),
		.arst_n_i	(arst_n_i),
		.wr_valid_i	(dec_valid),
		.wr_data_i	(dec_uop),
		.wr_ready_o	(dec_ready),
		.rd_valid_o	(uop_valid),
		.rd_data_o	(uop_data),
		.rd_ready_i	(uop_ready)
	);

	// single stage, regfile write and result load share the accept edge
	rv_execute u_execute (
		.clock_i	(clock_i),
		.arst_n_i	(arst_n_i),
		.uop_valid_i	(uop_valid),
		.uop_data_i	(uop_data),
		.uop_ready_o	(uop_ready),
		.wb_valid_o	(wb_valid_o),
		.wb_rd_o	(wb_rd_o),
		.wb_data_o	(wb_data_o),
		.wb_pc_o	(wb_pc_o),
		.wb_ready_i	(wb_ready_i)
	);

endmodule

/* rv_core_chk.sv */
module rv_core_chk import rv_pkg::*; (
	input	logic				clock_i,
	input	logic				arst_n_i,
	input	logic				inst_ready_o,
	input	logic				wb_valid_o,
	input	logic	[REG_AW-1:0]	wb_rd_o,
	input	logic	[XLEN-1:0]	wb_data_o,
	input	logic	[XLEN-1:0]	wb_pc_o,
	input	logic				wb_ready_i
);

	// failures seen so far, polled from the testbench
	int unsigned fail_count = 0;

	// stalled record holds until the sink takes it
	a_wb_stable: assert property (@(posedge clock_i) disable iff (!arst_n_i)
		wb_valid_o && !wb_ready_i |=> wb_valid_o && $stable(wb_rd_o) &&
			$stable(wb_data_o) && $stable(wb_pc_o))
	else begin
		fail_count++;
		$error("result record changed while the sink was stalling");
	end

	// both handshakes idle in reset
	a_reset_idle: assert property (@(posedge clock_i) !arst_n_i |-> !inst_ready_o && !wb_valid_o)
	else begin
		fail_count++;
		$error("handshake active during reset");
	end

	a_wb_valid_known: assert property (@(posedge clock_i) !$isunknown(wb_valid_o))
	else begin
		fail_count++;
		$error("wb_valid_o is unknown");
	end

endmodule

bind rv_core rv_core_chk i_chk (.*);

/* rv_core_tb.sv */
module rv_core_tb import rv_pkg::*; ();

	logic				clock;
	logic				arst_n;
	logic				inst_valid;
	logic	[XLEN-1:0]	inst_data;
	logic				inst_ready;
	logic				wb_valid;
	logic	[REG_AW-1:0]	wb_rd;
	logic	[XLEN-1:0]	wb_data;
	logic	[XLEN-1:0]	wb_pc;
	logic				wb_ready;

	integer				seed;
	bit					stall_en;
	bit					gap_en;
	string				test_name;

	// reference model, expected records are {rd, data, pc}
	logic	[XLEN-1:0]	regs [32];
	logic	[XLEN-1:0]	model_pc;
	logic	[68:0]		exp_q [$];

	rv_core i_dut (
		.clock_i		(clock),
		.arst_n_i		(arst_n),
		.inst_valid_i	(inst_valid),
		.inst_data_i	(inst_data),
		.inst_ready_o	(inst_ready),
		.wb_valid_o		(wb_valid),
		.wb_rd_o		(wb_rd),
		.wb_data_o		(wb_data),
		.wb_pc_o		(wb_pc),
		.wb_ready_i		(wb_ready)
	);

	initial begin
		clock = 1'b0;
		forever begin
			#50;
			clock = ~clock;
		end
	end

	// sink, stalls about one cycle in four when enabled
	always @(posedge clock) begin : sink
		logic ready_next;
		ready_next = stall_en ? (($random(seed) & 3) != 0) : 1'b1;
		#1;
		wb_ready = ready_next;
	end

	task automatic fail_stop(input string msg);
		$display("%s", msg);
		$display("Test failed");
		$fatal(1, "simulation stopped at first error");
	endtask

	task automatic check_value(input string what, input logic [31:0] expected,
			input logic [31:0] actual);
		if (expected !== actual) begin
			fail_stop($sformatf("FAIL %s %s: expected %h, actual %h", test_name, what,
				expected, actual));
		end
	endtask

	// legal OP, illegal OP, OP-IMM, LUI, AUIPC or a load
	function automatic logic [31:0] random_word();
		logic [31:0] r;
		logic [6:0] f7;
		r  = $random(seed);
		f7 = ((r[14:12] == 3'd0 || r[14:12] == 3'd5) && r[30]) ? 7'h20 : 7'h00;
		case ({$random(seed)} % 8)
			0, 1:    return {f7, r[24:7], OPC_OP};
			2:       return {7'h01, r[24:7], OPC_OP};
			3, 4:    return {(r[13:12] == 2'b01) ? {f7, r[24:20]} : r[31:20], r[19:7], OPC_OP_IMM};
			5:       return {r[31:7], OPC_LUI};
			6:       return {r[31:7], OPC_AUIPC};
			default: return {r[31:7], 7'b0000011};
		endcase
	endfunction

	task automatic model_accept(input logic [31:0] w);
		logic [6:0] opc;
		logic [2:0] f3;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] res;
		logic alt;
		logic legal;
		opc = w[6:0];
		f3  = w[14:12];
		a   = regs[w[19:15]];
		b   = (opc == OPC_OP) ? regs[w[24:20]] : {{20{w[31]}}, w[31:20]};
		// bit 30 picks SUB or SRA, never SUBI
		alt = w[30] && (opc == OPC_OP || f3 == 3'd5);
		case (f3)
			3'd0:    res = alt ? a - b : a + b;
			3'd1:    res = a << b[4:0];
			3'd2:    res = {31'd0, $signed(a) < $signed(b)};
			3'd3:    res = {31'd0, a < b};
			3'd4:    res = a ^ b;
			3'd5:    res = alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
			3'd6:    res = a | b;
			default: res = a & b;
		endcase
		if (opc == OPC_LUI) res = {w[31:12], 12'h000};
		if (opc == OPC_AUIPC) res = model_pc + {w[31:12], 12'h000};
		legal = (opc == OPC_OP_IMM) || (opc == OPC_LUI) || (opc == OPC_AUIPC) ||
			((opc == OPC_OP) && (w[31:25] == 7'h00 ||
			(w[31:25] == 7'h20 && (f3 == 3'd0 || f3 == 3'd5))));
		if (legal) begin
			exp_q.push_back({w[11:7], res, model_pc});
			if (w[11:7] != 5'd0) regs[w[11:7]] = res;
		end
		model_pc = model_pc + 32'd4;
	endtask

	// both handshakes sampled on the rising edge
	always @(posedge clock) begin : monitor
		logic [68:0] rec;
		if (arst_n && inst_valid && inst_ready) model_accept(inst_data);
		if (arst_n && wb_valid && wb_ready) begin
			if (exp_q.size() == 0) begin
				fail_stop("result record retired with no instruction pending");
			end else begin
				rec = exp_q.pop_front();
				check_value("rd", {27'd0, rec[68:64]}, {27'd0, wb_rd});
				check_value("data", rec[63:32], wb_data);
				check_value("pc", rec[31:0], wb_pc);
			end
		end
		if (i_dut.i_chk.fail_count != 0) fail_stop("a handshake assertion failed");
	end

	// called a little after an edge, returns a little after the accept edge
	task automatic send_word(input logic [31:0] w);
		int cycles;
		if (gap_en && (($random(seed) & 3) == 0)) begin
			inst_valid = 1'b0;
			repeat (1 + ($random(seed) & 3)) @(posedge clock);
			#1;
		end
		inst_valid = 1'b1;
		inst_data  = w;
		cycles     = 0;
		do begin
			@(posedge clock);
			cycles++;
			if (cycles > 100) fail_stop("instruction port never became ready");
		end while (!inst_ready);
		#1;
		inst_valid = 1'b0;
	endtask

	task automatic wait_drain();
		int cycles;
		cycles = 0;
		while (exp_q.size() != 0) begin
			@(posedge clock);
			#1;
			cycles++;
			if (cycles > 2000) fail_stop("pipeline did not retire all pending instructions");
		end
	endtask

	initial begin
		logic [31:0] rnd;
		int cycles;
		seed       = 32'hb0d3_1393;
		arst_n     = 1'b1;
		inst_valid = 1'b0;
		inst_data  = '0;
		wb_ready   = 1'b0;
		stall_en   = 1'b0;
		gap_en     = 1'b0;
		test_name  = "reset";
		model_pc   = RESET_PC;
		foreach (regs[i]) regs[i] = '0;
		#1 arst_n = 1'b0;
		repeat (8) @(posedge clock);
		#1 arst_n = 1'b1;

		// single word through an idle pipeline
		test_name = "latency";
		send_word({20'h12345, 5'd1, OPC_LUI});
		cycles = 0;
		do begin
			@(posedge clock);
			cycles++;
			if (cycles > 10) fail_stop("first result never appeared on the result port");
		end while (!wb_valid);
		check_value("cycles", 32'd3, cycles);
		wait_drain();

		// random values into every register, then x0 writes
		test_name = "fill";
		for (int r = 1; r < 32; r++) begin
			rnd = $random(seed);
			send_word({rnd[31:12], 5'(r), OPC_LUI});
			send_word({rnd[11:0], 5'(r), 3'b000, 5'(r), OPC_OP_IMM});
		end
		send_word({12'h7ff, 5'd0, 3'b000, 5'd0, OPC_OP_IMM});
		send_word({7'h00, 5'd3, 5'd0, 3'b000, 5'd2, OPC_OP});
		wait_drain();

		test_name = "random";
		stall_en  = 1'b1;
		gap_en    = 1'b1;
		repeat (400) send_word(random_word());
		wait_drain();
		repeat (10) @(posedge clock);

		if (i_dut.i_chk.fail_count != 0) begin
			fail_stop("handshake assertions failed during the run");
		end else begin
			$display("Test completed successfully");
			$finish;
		end
	end

endmodule

/* rv_decode.sv */
module rv_decode import rv_pkg::*; (
	input	logic				clock_i,
	input	logic				arst_n_i,

	// instruction words from the source
	input	logic				inst_valid_i,
	input	logic	[XLEN-1:0]	inst_data_i,
	output	logic				inst_ready_o,

	// decoded micro-op towards the FIFO
	output	logic				dec_valid_o,
	output	logic	[UOP_W-1:0]	dec_uop_o,
	input	logic				dec_ready_i
);

	logic				run_q;
	logic				valid_q;
	logic	[XLEN-1:0]	pc_q;
	logic	[UOP_W-1:0]	uop_q;

	opcode_e			opcode;
	alu_op_e			alu_op;
	logic	[2:0]		funct3;
	logic	[6:0]		funct7;
	logic	[XLEN-1:0]	imm;
	logic				legal;
	logic				use_imm;
	logic				use_pc;
	logic				zero_a;
	logic	[UOP_W-1:0]	uop_d;
	logic				inst_fire;

	// funct3 to ALU op, alt picks SUB or SRA
	function automatic alu_op_e f3_to_alu(input logic [2:0] f3, input logic alt);
		alu_op_e op;
		case (f3)
			3'b000:  op = alt ? ALU_SUB : ALU_ADD;
			3'b001:  op = ALU_SLL;
			3'b010:  op = ALU_SLT;
			3'b011:  op = ALU_SLTU;
			3'b100:  op = ALU_XOR;
			3'b101:  op = alt ? ALU_SRA : ALU_SRL;
			3'b110:  op = ALU_OR;
			default: op = ALU_AND;
		endcase
		return op;
	endfunction

	assign opcode = opcode_e'(inst_data_i[6:0]);
	assign funct3 = inst_data_i[14:12];
	assign funct7 = inst_data_i[31:25];

	always_comb begin
		alu_op  = ALU_ADD;
		imm     = {{(XLEN-12){inst_data_i[31]}}, inst_data_i[31:20]};
		legal   = 1'b0;
		use_imm = 1'b0;
		use_pc  = 1'b0;
		zero_a  = 1'b0;
		case (opcode)
			OPC_OP: begin
				// only SUB and SRA may set bit 30
				legal = (funct7 == 7'b0000000) ||
					((funct7 == 7'b0100000) && (funct3 == 3'b000 || funct3 == 3'b101));
				alu_op = f3_to_alu(funct3, inst_data_i[30]);
			end
			OPC_OP_IMM: begin
				legal   = 1'b1;
				use_imm = 1'b1;
				// addi has no subtract form
				alu_op  = f3_to_alu(funct3, (funct3 == 3'b101) && inst_data_i[30]);
			end
			OPC_LUI: begin
				legal   = 1'b1;
				use_imm = 1'b1;
				zero_a  = 1'b1;
				alu_op  = ALU_PASS_B;
				imm     = {inst_data_i[31:12], 12'b0};
			end
			OPC_AUIPC: begin
				legal   = 1'b1;
				use_imm = 1'b1;
				use_pc  = 1'b1;
				imm     = {inst_data_i[31:12], 12'b0};
			end
			default: legal = 1'b0;
		endcase
	end

	always_comb begin
		uop_d = '0;
		uop_d[UOP_ALU_LSB +: ALU_OP_W] = alu_op;
		uop_d[UOP_RD_LSB +: REG_AW]    = inst_data_i[11:7];
		uop_d[UOP_RS1_LSB +: REG_AW]   = inst_data_i[19:15];
		uop_d[UOP_RS2_LSB +: REG_AW]   = inst_data_i[24:20];
		uop_d[UOP_IMM_LSB +: XLEN]     = imm;
		uop_d[UOP_USE_IMM_BIT]         = use_imm;
		uop_d[UOP_USE_PC_BIT]          = use_pc;
		uop_d[UOP_ZERO_A_BIT]          = zero_a;
		uop_d[UOP_PC_LSB +: UOP_PC_W]  = pc_q[XLEN-1:2];
	end

	// output register empty or draining this cycle
	assign inst_ready_o = run_q & (~valid_q | dec_ready_i);
	assign inst_fire    = inst_valid_i & inst_ready_o;

	always_ff @(posedge clock_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			run_q   <= 1'b0;
			valid_q <= 1'b0;
			pc_q    <= RESET_PC;
		end else begin
			run_q <= 1'b1;
			// every accepted word takes a PC, dropped ones too
			if (inst_fire) begin
				pc_q <= pc_q + 32'd4;
			end
			valid_q <= (inst_fire & legal) | (valid_q & ~dec_ready_i);
		end
	end

	always_ff @(posedge clock_i) begin
		if (inst_fire && legal) begin
			uop_q <= uop_d;
		end
	end

	assign dec_valid_o = valid_q;
	assign dec_uop_o   = uop_q;

endmodule

/* rv_execute.sv */
module rv_execute import rv_pkg::*; (
	input	logic				clock_i,
	input	logic				arst_n_i,

	// micro-op from the FIFO head
	input	logic				uop_valid_i,
	input	logic	[UOP_W-1:0]	uop_data_i,
	output	logic				uop_ready_o,

	// retired instruction record
	output	logic				wb_valid_o,
	output	logic	[REG_AW-1:0]	wb_rd_o,
	output	logic	[XLEN-1:0]	wb_data_o,
	output	logic	[XLEN-1:0]	wb_pc_o,
	input	logic				wb_ready_i
);

	alu_op_e			alu_op;
	logic	[REG_AW-1:0]	rd;
	logic	[REG_AW-1:0]	rs1;
	logic	[REG_AW-1:0]	rs2;
	logic	[XLEN-1:0]	imm;
	logic				use_imm;
	logic				use_pc;
	logic				zero_a;
	logic	[XLEN-1:0]	pc;
	logic	[XLEN-1:0]	rs1_data;
	logic	[XLEN-1:0]	rs2_data;
	logic	[XLEN-1:0]	op_a;
	logic	[XLEN-1:0]	op_b;
	logic	[4:0]		shamt;
	logic	[XLEN-1:0]	alu_res;
	logic				fire;

	logic				wb_valid_q;
	logic	[REG_AW-1:0]	wb_rd_q;
	logic	[XLEN-1:0]	wb_data_q;
	logic	[XLEN-1:0]	wb_pc_q;

	// unpack micro-op
	assign alu_op  = alu_op_e'(uop_data_i[UOP_ALU_LSB +: ALU_OP_W]);
	assign rd      = uop_data_i[UOP_RD_LSB +: REG_AW];
	assign rs1     = uop_data_i[UOP_RS1_LSB +: REG_AW];
	assign rs2     = uop_data_i[UOP_RS2_LSB +: REG_AW];
	assign imm     = uop_data_i[UOP_IMM_LSB +: XLEN];
	assign use_imm = uop_data_i[UOP_USE_IMM_BIT];
	assign use_pc  = uop_data_i[UOP_USE_PC_BIT];
	assign zero_a  = uop_data_i[UOP_ZERO_A_BIT];
	assign pc      = {uop_data_i[UOP_PC_LSB +: UOP_PC_W], 2'b00};

	rv_regfile u_regfile (
		.clock_i	(clock_i),
		.arst_n_i	(arst_n_i),
		.rs1_i		(rs1),
		.rs2_i		(rs2),
		.we_i		(fire),
		.rd_i		(rd),
		.wdata_i	(alu_res),
		.rs1_data_o	(rs1_data),
		.rs2_data_o	(rs2_data)
	);

	assign op_a  = zero_a ? '0 : (use_pc ? pc : rs1_data);
	assign op_b  = use_imm ? imm : rs2_data;
	assign shamt = op_b[4:0];

	always_comb begin
		case (alu_op)
			ALU_ADD:    alu_res = op_a + op_b;
			ALU_SUB:    alu_res = op_a - op_b;
			ALU_SLL:    alu_res = op_a << shamt;
			ALU_SLT:    alu_res = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
			ALU_SLTU:   alu_res = {{(XLEN-1){1'b0}}, op_a < op_b};
			ALU_XOR:    alu_res = op_a ^ op_b;
			ALU_SRL:    alu_res = op_a >> shamt;
			ALU_SRA:    alu_res = $unsigned($signed(op_a) >>> shamt);
			ALU_OR:     alu_res = op_a | op_b;
			ALU_AND:    alu_res = op_a & op_b;
			ALU_PASS_B: alu_res = op_b;
			default:    alu_res = '0;
		endcase
	end

	// result register empty or being taken by the sink
	assign uop_ready_o = ~wb_valid_q | wb_ready_i;
	assign fire        = uop_valid_i & uop_ready_o;

	always_ff @(posedge clock_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			wb_valid_q <= 1'b0;
		end else if (fire) begin
			wb_valid_q <= 1'b1;
		end else if (wb_ready_i) begin
			wb_valid_q <= 1'b0;
		end
	end

	always_ff @(posedge clock_i) begin
		if (fire) begin
			wb_rd_q   <= rd;
			wb_data_q <= alu_res;
			wb_pc_q   <= pc;
		end
	end

	assign wb_valid_o = wb_valid_q;
	assign wb_rd_o    = wb_rd_q;
	assign wb_data_o  = wb_data_q;
	assign wb_pc_o    = wb_pc_q;

endmodule

/* rv_pkg.sv */
package rv_pkg;

	// datapath and register index widths
	localparam int XLEN   = 32;
	localparam int REG_AW = 5;

	// first PC handed out after reset
	localparam logic [XLEN-1:0] RESET_PC = 32'h8000_0000;

	// default micro-op FIFO depth, must be a power of two
	localparam int UOP_FIFO_DEPTH = 4;

	// major opcodes the core executes, every other encoding is dropped
	typedef enum logic [6:0] {
		OPC_OP     = 7'b0110011,
		OPC_OP_IMM = 7'b0010011,
		OPC_LUI    = 7'b0110111,
		OPC_AUIPC  = 7'b0010111
	} opcode_e;

	// ALU operations
	typedef enum logic [3:0] {
		ALU_ADD    = 4'd0,
		ALU_SUB    = 4'd1,
		ALU_SLL    = 4'd2,
		ALU_SLT    = 4'd3,
		ALU_SLTU   = 4'd4,
		ALU_XOR    = 4'd5,
		ALU_SRL    = 4'd6,
		ALU_SRA    = 4'd7,
		ALU_OR     = 4'd8,
		ALU_AND    = 4'd9,
		ALU_PASS_B = 4'd10
	} alu_op_e;

	// micro-op field sizes
	localparam int ALU_OP_W = 4;
	// PC is stored word aligned, low two bits implied zero
	localparam int UOP_PC_W = XLEN - 2;

	// micro-op field positions, PC sits at the bottom
	localparam int UOP_PC_LSB      = 0;
	localparam int UOP_ZERO_A_BIT  = UOP_PC_LSB + UOP_PC_W;
	localparam int UOP_USE_PC_BIT  = UOP_ZERO_A_BIT + 1;
	localparam int UOP_USE_IMM_BIT = UOP_USE_PC_BIT + 1;
	localparam int UOP_IMM_LSB     = UOP_USE_IMM_BIT + 1;
	localparam int UOP_RS2_LSB     = UOP_IMM_LSB + XLEN;
	localparam int UOP_RS1_LSB     = UOP_RS2_LSB + REG_AW;
	localparam int UOP_RD_LSB      = UOP_RS1_LSB + REG_AW;
	localparam int UOP_ALU_LSB     = UOP_RD_LSB + REG_AW;

	// total packed width, 84 bits
	localparam int UOP_W = UOP_ALU_LSB + ALU_OP_W;

endpackage

/* rv_regfile.sv */
module rv_regfile import rv_pkg::*; (
	input	logic				clock_i,
	input	logic				arst_n_i,
	input	logic	[REG_AW-1:0]	rs1_i,
	input	logic	[REG_AW-1:0]	rs2_i,
	input	logic				we_i,
	input	logic	[REG_AW-1:0]	rd_i,
	input	logic	[XLEN-1:0]	wdata_i,
	output	logic	[XLEN-1:0]	rs1_data_o,
	output	logic	[XLEN-1:0]	rs2_data_o
);

	// x1..x31 only, x0 has no storage
	logic	[XLEN-1:0]	regs_q [1:31];

	always_ff @(posedge clock_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			for (int i = 1; i < 32; i++) begin
				regs_q[i] <= '0;
			end
		end else if (we_i && (rd_i != '0)) begin
			regs_q[rd_i] <= wdata_i;
		end
	end

	assign rs1_data_o = (rs1_i == '0) ? '0 : regs_q[rs1_i];
	assign rs2_data_o = (rs2_i == '0) ? '0 : regs_q[rs2_i];

endmodule

/* rv_uop_fifo.sv */
module rv_uop_fifo import rv_pkg::*; #(
	parameter int DEPTH = UOP_FIFO_DEPTH
) (
	input	logic				clock_i,
	input	logic				arst_n_i,

	// write side
	input	logic				wr_valid_i,
	input	logic	[UOP_W-1:0]	wr_data_i,
	output	logic				wr_ready_o,

	// read side, head entry
	output	logic				rd_valid_o,
	output	logic	[UOP_W-1:0]	rd_data_o,
	input	logic				rd_ready_i
);

	localparam int AW = $clog2(DEPTH);

	logic	[UOP_W-1:0]	mem_q [DEPTH];
	logic	[AW-1:0]	wr_ptr_q;
	logic	[AW-1:0]	rd_ptr_q;
	logic	[AW:0]		count_q;
	logic				full;
	logic				wr_fire;
	logic				rd_fire;

	// depth is a power of two, so the top count bit means full
	assign full       = count_q[AW];
	assign rd_valid_o = |count_q;
	// a full FIFO still takes a word when the head leaves this cycle
	assign wr_ready_o = ~full | rd_ready_i;

	assign wr_fire = wr_valid_i & wr_ready_o;
	assign rd_fire = rd_valid_o & rd_ready_i;

	assign rd_data_o = mem_q[rd_ptr_q];

	always_ff @(posedge clock_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			count_q  <= '0;
		end else begin
			if (wr_fire) begin
				wr_ptr_q <= wr_ptr_q + 1'b1;
			end
			if (rd_fire) begin
				rd_ptr_q <= rd_ptr_q + 1'b1;
			end
			case ({wr_fire, rd_fire})
				2'b10:   count_q <= count_q + 1'b1;
				2'b01:   count_q <= count_q - 1'b1;
				default: count_q <= count_q;
			endcase
		end
	end

	// storage
	always_ff @(posedge clock_i) begin
		if (wr_fire) begin
			mem_q[wr_ptr_q] <= wr_data_i;
		end
	end

endmodule
